/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - source
    files:
      - source/fetch_pkg.sv
      - source/fetch_csr.sv
      - source/fetch_pc_gen.sv
      - source/iaddr_trans.sv
      - source/fetch_frontend.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_clk_gen.sv
      - tb/fetch_frontend_chk.sv
      - tb/fetch_frontend_tb.sv

/* source/fetch_csr.sv */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_csr import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_i,

  input  logic        we_i,
  input  csr_sel_e    sel_i,
  input  logic [31:0] wdata_i,

  output csr_t        csr_o,
  output logic        flush_o
);

  csr_t csr_q;
  logic flush_q;

  // ============================================================
  // Register file
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst_i) begin
      csr_q                <= '0;
      csr_q.crmd[`CRMD_DA] <= 1'b1; // come out of reset in direct address mode.
    end else if (we_i) begin
      case (sel_i)
        CSR_CRMD: csr_q.crmd <= wdata_i;
        CSR_DMW0: csr_q.dmw0 <= wdata_i;
        CSR_DMW1: csr_q.dmw1 <= wdata_i;
        default: ; // unused encoding writes nothing.
      endcase
    end
  end

  // ============================================================
  // Flush pulse
  // ============================================================
  // Any write changes how the request in flight was translated, so the
  // pulse lines up with the first cycle that shows the new values.
  always_ff @(posedge clk) begin
    if (rst_i) begin
      flush_q <= 1'b0;
    end else begin
      flush_q <= we_i;
    end
  end

  assign csr_o   = csr_q;
  assign flush_o = flush_q;

endmodule

/* source/fetch_defs.svh */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// ============================================================
// Fetch address after reset
// ============================================================
`define FETCH_RESET_PC 32'h1c000000

// ============================================================
// crmd fields
// ============================================================
`define CRMD_PLV  1:0 // current privilege level.
`define CRMD_DA   3   // direct address translation enable.
`define CRMD_DATF 6:5 // memory access type for instruction fetch in DA mode.

// ============================================================
// Direct mapping window fields (dmw0, dmw1)
// ============================================================
`define DMW_PLV0 0     // window usable at privilege level 0.
`define DMW_PLV3 3     // window usable at privilege level 3.
`define DMW_MAT  5:4   // memory access type of the window.
`define DMW_PSEG 27:25 // physical segment, placed in paddr bits 31:29.
`define DMW_VSEG 31:29 // virtual segment, compared with vaddr bits 31:29.

`endif

/* source/fetch_frontend.sv */
`timescale 1ns/1ps

module fetch_frontend import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        f_stall_i,

  input  logic        redirect_i,
  input  logic [31:0] redirect_pc_i,

  input  logic        csr_we_i,
  input  csr_sel_e    csr_sel_i,
  input  logic [31:0] csr_wdata_i,

  output fetch_req_t  fetch_o
);

  csr_t        csr;
  logic        flush;
  logic [31:0] pc;
  logic        pc_valid;
  logic [31:0] stage_pc;

  fetch_csr csr_i (
    .clk     (clk),
    .rst_i   (rst_i),
    .we_i    (csr_we_i),
    .sel_i   (csr_sel_i),
    .wdata_i (csr_wdata_i),
    .csr_o   (csr),
    .flush_o (flush)
  );

  fetch_pc_gen pc_gen_i (
    .clk           (clk),
    .rst_i         (rst_i),
    .stall_i       (f_stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .flush_i       (flush),
    .refetch_pc_i  (stage_pc),
    .pc_o          (pc),
    .valid_o       (pc_valid)
  );

  iaddr_trans trans_i (
    .clk        (clk),
    .rst_i      (rst_i),
    .valid_i    (pc_valid),
    .vaddr_i    (pc),
    .stall_i    (f_stall_i),
    .flush_i    (flush),
    .csr_i      (csr),
    .req_o      (fetch_o),
    .stage_pc_o (stage_pc)
  );

endmodule

/* source/fetch_pc_gen.sv */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_pc_gen (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        stall_i,

  input  logic        redirect_i,
  input  logic [31:0] redirect_pc_i,

  input  logic        flush_i,
  input  logic [31:0] refetch_pc_i,

  output logic [31:0] pc_o,
  output logic        valid_o
);

  logic [31:0] pc_q;
  logic [31:0] pc_d;
  logic        valid_q;

  // redirect beats refetch, and both beat the sequential step.
  always_comb begin
    pc_d = pc_q;
    if (redirect_i) begin
      pc_d = redirect_pc_i;
    end else if (flush_i) begin
      pc_d = refetch_pc_i;
    end else if (valid_q && !stall_i) begin
      pc_d = pc_q + 32'd4; // next sequential word.
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q    <= `FETCH_RESET_PC;
      valid_q <= 1'b0;
    end else begin
      pc_q    <= pc_d;
      valid_q <= 1'b1; // fetching runs without a break once out of reset.
    end
  end

  assign pc_o    = pc_q;
  assign valid_o = valid_q;

endmodule

/* source/fetch_pkg.sv */
package fetch_pkg;

  // translation control registers seen by the fetch path.
  typedef struct packed {
    logic [31:0] crmd;
    logic [31:0] dmw0;
    logic [31:0] dmw1;
  } csr_t;

  // target of a control register write.
  typedef enum logic [1:0] {
    CSR_CRMD = 2'd0,
    CSR_DMW0 = 2'd1,
    CSR_DMW1 = 2'd2
  } csr_sel_e;

  // Exception flags raised on the fetch path. Only adef is produced
  // without a TLB, the others stay zero.
  typedef struct packed {
    logic adef;
    logic tlbr;
    logic pif;
    logic ppi;
  } fetch_excp_t;

  // request handed to the cache stage.
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;       // virtual fetch address.
    logic [31:0] paddr;
    logic        uncached;
    fetch_excp_t excp;
  } fetch_req_t;

endpackage

/* source/iaddr_trans.sv */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module iaddr_trans import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_i,

  input  logic        valid_i,
  input  logic [31:0] vaddr_i,

  input  logic        stall_i,
  input  logic        flush_i,

  input  csr_t        csr_i,

  output fetch_req_t  req_o,
  output logic [31:0] stage_pc_o
);

  // ============================================================
  // Mode and window decode
  // ============================================================
  logic       da_mode;
  logic [1:0] da_matf;
  logic       plv0;
  logic       plv3;
  logic       dmw0_hit;
  logic       dmw1_hit;
  logic       uncached;
  logic [2:0] pseg;
  logic       adef;

  assign da_mode = csr_i.crmd[`CRMD_DA];
  assign da_matf = csr_i.crmd[`CRMD_DATF];
  assign plv0    = csr_i.crmd[`CRMD_PLV] == 2'd0;
  assign plv3    = csr_i.crmd[`CRMD_PLV] == 2'd3;

  assign dmw0_hit = ((csr_i.dmw0[`DMW_PLV0] && plv0) || (csr_i.dmw0[`DMW_PLV3] && plv3)) &&
                    (csr_i.dmw0[`DMW_VSEG] == vaddr_i[31:29]);
  assign dmw1_hit = ((csr_i.dmw1[`DMW_PLV0] && plv0) || (csr_i.dmw1[`DMW_PLV3] && plv3)) &&
                    (csr_i.dmw1[`DMW_VSEG] == vaddr_i[31:29]);

  always_comb begin
    if (da_mode) begin
      pseg     = vaddr_i[31:29]; // identity mapping.
      uncached = da_matf != 2'd1;
    end else if (dmw0_hit) begin
      pseg     = csr_i.dmw0[`DMW_PSEG]; // dmw0 has priority.
      uncached = csr_i.dmw0[`DMW_MAT] != 2'd1;
    end else begin
      pseg     = csr_i.dmw1[`DMW_PSEG];
      uncached = csr_i.dmw1[`DMW_MAT] != 2'd1;
    end
  end

  assign adef = (|vaddr_i[1:0]) || (!da_mode && !dmw0_hit && !dmw1_hit);

  // ============================================================
  // Stage registers
  // ============================================================
  logic        valid_q;
  logic [31:0] pc_q;
  logic [31:0] paddr_q;
  logic        uncached_q;
  logic        adef_q;

  // A flush drops whatever was sampled on the same edge too, since the PC
  // generator refetches the killed address afterwards.
  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (!stall_i) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      pc_q       <= vaddr_i;
      paddr_q    <= {pseg, vaddr_i[28:0]};
      uncached_q <= uncached;
      adef_q     <= adef;
    end
  end

  always_comb begin
    req_o.valid     = valid_q && !flush_i; // stale translation is not passed on.
    req_o.pc        = pc_q;
    req_o.paddr     = paddr_q;
    req_o.uncached  = uncached_q;
    req_o.excp.adef = adef_q;
    req_o.excp.tlbr = 1'b0;
    req_o.excp.pif  = 1'b0;
    req_o.excp.ppi  = 1'b0;
  end

  // oldest address not yet delivered. With the stage empty it is still
  // waiting at the input.
  assign stage_pc_o = valid_q ? pc_q : vaddr_i;

endmodule

/* src.f */
+incdir+source
source/fetch_pkg.sv
source/fetch_csr.sv
source/fetch_pc_gen.sv
source/iaddr_trans.sv
source/fetch_frontend.sv
tb/tb_clk_gen.sv
tb/fetch_frontend_chk.sv
tb/fetch_frontend_tb.sv

/* tb/fetch_frontend_chk.sv */
`timescale 1ns/1ps

module fetch_frontend_chk import fetch_pkg::*; (
  input logic       clk,
  input logic       rst_i,
  input logic       stall_i,
  input logic       flush_i,
  input fetch_req_t req_o
);

  // the stage comes out of reset empty.
  valid_after_reset: assert property (@(posedge clk) rst_i |=> !req_o.valid)
    else $error("fetch request valid right after reset");

  // a killed request is not passed on in the following cycle.
  flush_kills: assert property (@(posedge clk) disable iff (rst_i)
    flush_i |=> !req_o.valid)
    else $error("fetch request valid in the cycle after a flush");

  // the downstream stage sees a steady request while it stalls.
  stall_holds: assert property (@(posedge clk) disable iff (rst_i)
    stall_i |=> $stable({req_o.pc, req_o.paddr, req_o.uncached, req_o.excp}))
    else $error("fetch request changed under stall");

endmodule

/* tb/fetch_frontend_tb.sv */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_frontend_tb import fetch_pkg::*; ();

  localparam int N_SEQ       = 16;
  localparam int N_STALL     = 40;
  localparam int N_MAP_ITER  = 12;
  localparam int N_MAP_RUN   = 6;
  localparam int MAX_CYCLES  = 4 * (2 * N_SEQ + 2 * N_STALL +
                                    N_MAP_ITER * (N_MAP_RUN + 16) + 60) + 200;

  logic        clk;
  logic        rst_i;
  logic        stall;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic        csr_we;
  csr_sel_e    csr_sel;
  logic [31:0] csr_wdata;
  fetch_req_t  fetch_o;

  csr_t        model;                      // CSR values as written by the testbench.
  logic [31:0] rng = 32'h1e88;
  logic [31:0] exp_pc = `FETCH_RESET_PC;
  logic        redir_pending = 1'b0;
  logic [31:0] redir_target;
  int          errors = 0;
  int          deliveries = 0;
  int          adef_seen = 0;
  int          cycles = 0;
  fetch_req_t  want;

  tb_clk_gen clk_gen_i (.clk(clk), .rst_i(rst_i));

  fetch_frontend dut_i (
    .clk           (clk),
    .rst_i         (rst_i),
    .f_stall_i     (stall),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .csr_we_i      (csr_we),
    .csr_sel_i     (csr_sel),
    .csr_wdata_i   (csr_wdata),
    .fetch_o       (fetch_o)
  );

  bind iaddr_trans fetch_frontend_chk chk_i (
    .clk(clk), .rst_i(rst_i), .stall_i(stall_i), .flush_i(flush_i), .req_o(req_o)
  );

  // ============================================================
  // Reference model and helpers
  // ============================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic window_hit(input logic [31:0] dmw, input logic [1:0] plv,
                                      input logic [31:0] vpc);
    logic plv_ok;
    plv_ok = (dmw[`DMW_PLV0] && plv == 2'd0) || (dmw[`DMW_PLV3] && plv == 2'd3);
    return plv_ok && dmw[`DMW_VSEG] == vpc[31:29];
  endfunction

  function automatic fetch_req_t expected_req(input logic [31:0] vpc, input csr_t m);
    fetch_req_t r;
    logic       hit0;
    logic       hit1;
    r       = '0;
    r.valid = 1'b1;
    r.pc    = vpc;
    hit0    = window_hit(m.dmw0, m.crmd[`CRMD_PLV], vpc);
    hit1    = window_hit(m.dmw1, m.crmd[`CRMD_PLV], vpc);
    r.excp.adef = vpc[1:0] != 2'b00;
    if (m.crmd[`CRMD_DA]) begin
      r.paddr    = vpc;
      r.uncached = m.crmd[`CRMD_DATF] != 2'd1;
    end else begin
      r.paddr    = {hit0 ? m.dmw0[`DMW_PSEG] : m.dmw1[`DMW_PSEG], vpc[28:0]};
      r.uncached = (hit0 ? m.dmw0[`DMW_MAT] : m.dmw1[`DMW_MAT]) != 2'd1;
      if (!hit0 && !hit1) begin
        r.excp.adef = 1'b1; // no window maps this address.
      end
    end
    return r;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  // ============================================================
  // Comparison of delivered requests
  // ============================================================
  always @(negedge clk) begin
    if (!rst_i && fetch_o.valid === 1'b1 && stall === 1'b0) begin
      if (fetch_o.pc !== exp_pc) begin
        $display("request out of order or missing: fetched pc 0x%08h while 0x%08h was due",
                 fetch_o.pc, exp_pc);
        errors++;
      end
      want = expected_req(fetch_o.pc, model);
      check_val("fetch_o.excp.adef", fetch_o.excp.adef, want.excp.adef);
      check_val("fetch_o.excp.tlbr", fetch_o.excp.tlbr, 1'b0);
      check_val("fetch_o.excp.pif", fetch_o.excp.pif, 1'b0);
      check_val("fetch_o.excp.ppi", fetch_o.excp.ppi, 1'b0);
      check_val("fetch_o.paddr", fetch_o.paddr, want.paddr);
      check_val("fetch_o.uncached", fetch_o.uncached, want.uncached);
      if (fetch_o.excp.adef) adef_seen++;
      deliveries++;
      exp_pc = fetch_o.pc + 32'd4; // resync so one slip is reported once.
      if (redir_pending) begin
        exp_pc        = redir_target;
        redir_pending = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: no progress after %0d cycles, %0d requests seen", cycles, deliveries);
      $display("Test failures found");
      $finish;
    end
  end

  // ============================================================
  // Stimulus tasks
  // ============================================================
  task automatic wait_deliveries(input int n, input logic random_stall);
    int target;
    target = deliveries + n;
    while (deliveries < target) begin
      @(posedge clk);
      rng = xorshift32(rng);
      stall <= random_stall ? rng[0] : 1'b0;
    end
    @(posedge clk);
    stall <= 1'b0;
  endtask

  task automatic csr_write(input csr_sel_e sel, input logic [31:0] data);
    @(posedge clk);
    csr_we    <= 1'b1;
    csr_sel   <= sel;
    csr_wdata <= data;
    @(posedge clk);
    csr_we <= 1'b0;
    case (sel)
      CSR_CRMD: model.crmd = data;
      CSR_DMW0: model.dmw0 = data;
      default:  model.dmw1 = data;
    endcase
    @(negedge clk);
    check_val("fetch_o.valid", fetch_o.valid, 1'b0); // flush cycle.
  endtask

  task automatic do_redirect(input logic [31:0] target);
    @(posedge clk);
    stall       <= 1'b0;
    redirect    <= 1'b1;
    redirect_pc <= target;
    @(posedge clk);
    redirect      <= 1'b0;
    redir_target  = target;
    redir_pending = 1'b1; // one older request still drains first.
    @(posedge clk);
    @(negedge clk);
    check_val("fetch_o.valid", fetch_o.valid, 1'b1); // two cycles after the pulse.
    check_val("fetch_o.pc", fetch_o.pc, target);
  endtask

  task automatic report(input int num, input string name, input int start_errors);
    $display("test %0d (%s) finished with %0d errors", num, name, errors - start_errors);
  endtask

  // ============================================================
  // Test sequence
  // ============================================================
  initial begin
    int          e0;
    int          adef0;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] crmd;
    logic [31:0] pc;
    stall       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    csr_we      = 1'b0;
    csr_sel     = CSR_CRMD;
    csr_wdata   = '0;
    model       = '0;
    model.crmd[`CRMD_DA] = 1'b1;
    @(negedge rst_i);

    e0 = errors;
    wait_deliveries(N_SEQ, 1'b0);
    csr_write(CSR_CRMD, 32'h0000_0028); // DA with DATF = 1.
    wait_deliveries(N_SEQ / 2, 1'b0);
    report(1, "direct address sequence", e0);

    e0 = errors;
    rng = xorshift32(rng);
    do_redirect({rng[31:2], 2'b00});
    wait_deliveries(6, 1'b0);
    wait_deliveries(N_STALL, 1'b1);
    report(4, "redirect and stall", e0);

    e0 = errors;
    csr_write(CSR_CRMD, 32'h0000_0008);
    wait_deliveries(4, 1'b0);
    csr_write(CSR_CRMD, 32'h0000_0028);
    wait_deliveries(4, 1'b0);
    report(5, "refetch after CSR write", e0);

    e0 = errors;
    for (int i = 0; i < N_MAP_ITER; i++) begin
      rng = xorshift32(rng);
      d0  = rng;
      rng = xorshift32(rng);
      d1  = rng;
      if (rng[7]) d1[`DMW_VSEG] = d0[`DMW_VSEG]; // both windows hit.
      crmd = '0;
      crmd[`CRMD_PLV]  = rng[9] ? 2'd3 : 2'd0;
      crmd[`CRMD_DATF] = rng[11:10];
      csr_write(CSR_DMW0, d0);
      csr_write(CSR_DMW1, d1);
      csr_write(CSR_CRMD, crmd);
      rng = xorshift32(rng);
      pc  = {rng[31:2], 2'b00};
      if (rng[1:0] == 2'd0) pc[31:29] = d0[`DMW_VSEG];
      if (rng[1:0] == 2'd1) pc[31:29] = d1[`DMW_VSEG];
      do_redirect(pc);
      wait_deliveries(N_MAP_RUN, 1'b0);
    end
    csr_write(CSR_CRMD, 32'h0000_0008);
    wait_deliveries(4, 1'b0);
    report(2, "mapped windows", e0);

    e0    = errors;
    adef0 = adef_seen;
    rng   = xorshift32(rng);
    do_redirect({rng[31:2], 2'b10});
    wait_deliveries(4, 1'b0);
    csr_write(CSR_DMW0, 32'h0);
    csr_write(CSR_DMW1, 32'h0);
    csr_write(CSR_CRMD, 32'h0);
    do_redirect({rng[31:12], 12'h000});
    wait_deliveries(4, 1'b0);
    if (adef_seen < adef0 + 8) begin
      $display("address errors missing: only %0d raised", adef_seen - adef0);
      errors++;
    end
    csr_write(CSR_CRMD, 32'h0000_0008);
    wait_deliveries(4, 1'b0);
    report(3, "address error", e0);

    $display("summary: %0d requests checked, %0d errors", deliveries, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_i
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period.
  end

  initial begin
    rst_i = 1'b1;
    repeat (3) @(posedge clk);
    rst_i <= 1'b0;
  end

endmodule
